// ==== design/vram_pkg.sv ====
`default_nettype none

package vram_pkg;

    typedef logic [7:0]  byte_t;         // one byte on the host bus
    typedef logic [15:0] word_t;         // register or vram word
    typedef logic [3:0]  reg_num_t;      // register number from the bus
    typedef logic [15:0] vram_addr_t;    // vram word address as the host sees it

    // register map
    localparam reg_num_t REG_WR_ADDR    = 4'd0;    // vram write pointer
    localparam reg_num_t REG_WR_DATA    = 4'd1;    // writing queues a vram write
    localparam reg_num_t REG_RD_ADDR    = 4'd2;    // vram read pointer, writing starts a prefetch
    localparam reg_num_t REG_RD_DATA    = 4'd3;    // prefetched word, read only
    localparam reg_num_t REG_INCR       = 4'd4;    // step added to both pointers
    localparam reg_num_t REG_STATUS     = 4'd5;    // read only
    localparam reg_num_t REG_SCRATCH_LO = 4'd6;    // first scratch register, the rest run up to 15

    localparam int STATUS_BUSY_BIT = 0;    // write waiting for a credit or prefetch still open

    // one request slot in the vram queue
    typedef struct packed {
        logic       wr;      // high for a write
        vram_addr_t addr;    // full host address, memory uses the low bits
        word_t      data;    // write data, ignored on reads
    } vram_req_t;

    // read prefetch states
    typedef enum logic [1:0] {
        RD_IDLE,     // word in RD_DATA is current
        RD_ISSUE,    // waiting for a credit to send the read
        RD_WAIT      // read sent, waiting for the response
    } rd_state_t;

endpackage

`default_nettype wire

// ==== design/bus_interface.sv ====
`default_nettype none
`timescale 1ns/1ps

module bus_interface (
    input  logic               clk,
    input  logic               reset_i,
    input  logic               bus_cs_n_i,       // select, active low
    input  logic               bus_rd_nwr_i,     // high for a read
    input  vram_pkg::reg_num_t bus_reg_num_i,
    input  logic               bus_bytesel_i,    // low for the even (high) byte
    input  vram_pkg::byte_t    bus_data_i,
    output vram_pkg::byte_t    bus_data_o,
    output logic               write_strobe_o,   // one cycle, odd byte writes only
    output logic               read_strobe_o,    // one cycle per read access
    output vram_pkg::reg_num_t reg_num_o,
    output vram_pkg::word_t    reg_data_o,       // paired word for the write strobe
    input  vram_pkg::word_t    reg_data_i        // read word for reg_num_o
);

    // bus inputs that are sampled together
    typedef struct packed {
        logic               rd;
        logic               bytesel;
        vram_pkg::reg_num_t reg_num;
        vram_pkg::byte_t    data;
    } bus_sample_t;

    bus_sample_t        bus_s1;       // first synchronizer stage
    bus_sample_t        bus_s2;       // second stage, this one is acted on
    logic [1:0]         sel_sync;     // inverted select, [1] is synchronized
    logic               sel_d;        // synchronized select one clock back
    logic               sel_edge;     // registered rising edge of select

    vram_pkg::reg_num_t even_reg;     // register the buffered even byte belongs to
    vram_pkg::byte_t    even_data;    // even byte, sent as the high byte
    logic               bytesel_q;    // byte lane lined up with reg_num_o
    logic               rd_held;      // read byte frozen until select goes away
    vram_pkg::byte_t    rd_hold;      // byte captured at the read edge
    vram_pkg::byte_t    rd_live;      // lane of reg_data_i picked by bytesel

    assign rd_live    = bytesel_q ? reg_data_i[7:0] : reg_data_i[15:8];
    // a prefetch started by this access must not change the byte the host is sampling
    assign bus_data_o = rd_held ? rd_hold : rd_live;

    always_ff @(posedge clk) begin
        bus_s1 <= {bus_rd_nwr_i, bus_bytesel_i, bus_reg_num_i, bus_data_i};
        bus_s2 <= bus_s1;
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            sel_sync       <= 2'b00;
            sel_d          <= 1'b0;
            sel_edge       <= 1'b0;
            write_strobe_o <= 1'b0;
            read_strobe_o  <= 1'b0;
            reg_num_o      <= '0;
            bytesel_q      <= 1'b0;
            even_reg       <= '0;
            even_data      <= '0;
            rd_held        <= 1'b0;
        end else begin
            sel_sync       <= {sel_sync[0], ~bus_cs_n_i};    // active high from here on
            sel_d          <= sel_sync[1];
            sel_edge       <= sel_sync[1] & ~sel_d;          // start of an access
            reg_num_o      <= bus_s2.reg_num;                // follows the bus every clock
            bytesel_q      <= bus_s2.bytesel;
            write_strobe_o <= 1'b0;
            read_strobe_o  <= 1'b0;

            if (!sel_sync[1]) begin
                rd_held <= 1'b0;                             // access over, show live byte
            end

            if (sel_edge) begin
                if (bus_s2.rd) begin
                    read_strobe_o <= 1'b1;
                    rd_held       <= 1'b1;
                end else if (bus_s2.bytesel) begin
                    write_strobe_o <= 1'b1;                  // odd byte completes the word
                end else begin
                    even_reg  <= bus_s2.reg_num;             // keep even byte for the odd one
                    even_data <= bus_s2.data;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (sel_edge && bus_s2.rd) begin
            rd_hold <= rd_live;
        end
        if (sel_edge && !bus_s2.rd && bus_s2.bytesel) begin
            if (bus_s2.reg_num == even_reg) begin
                reg_data_o <= {even_data, bus_s2.data};     // matching pair
            end else begin
                reg_data_o <= {8'h00, bus_s2.data};          // lone odd byte, high byte zero
            end
        end
    end

endmodule

`default_nettype wire

// ==== design/reg_block.sv ====
`default_nettype none
`timescale 1ns/1ps

module reg_block #(
    parameter int VRAM_AW     = 10,
    parameter int QUEUE_DEPTH = 4
) (
    input  logic                clk,
    input  logic                reset_i,
    input  logic                write_strobe_i,
    input  logic                read_strobe_i,
    input  vram_pkg::reg_num_t  reg_num_i,
    input  vram_pkg::word_t     reg_data_i,
    output vram_pkg::word_t     rd_word_o,          // read word for reg_num_i, no clock
    output logic                req_valid_o,        // only while a credit is left
    output vram_pkg::vram_req_t req_o,
    input  logic                credit_return_i,    // one queue slot freed
    input  logic                rsp_valid_i,
    input  vram_pkg::word_t     rsp_data_i
);

    localparam int CREDIT_W    = $clog2(QUEUE_DEPTH + 1);
    localparam int NUM_SCRATCH = 16 - int'(vram_pkg::REG_SCRATCH_LO);
    localparam vram_pkg::vram_addr_t ADDR_MASK =
        vram_pkg::vram_addr_t'((32'd1 << VRAM_AW) - 1);    // host addresses alias in memory

    vram_pkg::vram_addr_t wr_addr;         // next vram write address
    vram_pkg::vram_addr_t rd_addr;         // address of the prefetched word
    vram_pkg::word_t      incr;            // pointer step
    vram_pkg::word_t      wr_data;         // last word written, also the pending write data
    vram_pkg::word_t      rd_data;         // prefetched word
    vram_pkg::word_t      scratch [NUM_SCRATCH];
    logic                 wr_pend;         // write waiting for a credit
    vram_pkg::vram_addr_t wr_pend_addr;    // address taken when the write arrived
    logic                 rd_odd;          // next RD_DATA read strobe is the odd byte
    vram_pkg::rd_state_t  rd_state;
    logic [CREDIT_W-1:0]  credits;         // free slots in the vram queue

    logic                 have_credit;
    logic                 rd_issue;        // prefetch read leaves this cycle
    logic                 busy;
    logic [3:0]           scratch_idx;
    logic                 rd_data_strobe;  // read strobe on RD_DATA

    assign have_credit    = (credits != '0);
    assign req_valid_o    = have_credit && (wr_pend || rd_state == vram_pkg::RD_ISSUE);
    assign rd_issue       = req_valid_o && !wr_pend;     // pending write goes first
    assign busy           = wr_pend || (rd_state != vram_pkg::RD_IDLE);
    assign scratch_idx    = reg_num_i - vram_pkg::REG_SCRATCH_LO;
    assign rd_data_strobe = read_strobe_i && (reg_num_i == vram_pkg::REG_RD_DATA);

    always_comb begin
        req_o      = '0;
        req_o.wr   = wr_pend;
        req_o.addr = (wr_pend ? wr_pend_addr : rd_addr) & ADDR_MASK;
        req_o.data = wr_data;                            // don't care for reads
    end

    always_comb begin
        rd_word_o = '0;
        case (reg_num_i)
            vram_pkg::REG_WR_ADDR: rd_word_o = wr_addr;
            vram_pkg::REG_WR_DATA: rd_word_o = wr_data;
            vram_pkg::REG_RD_ADDR: rd_word_o = rd_addr;
            vram_pkg::REG_RD_DATA: rd_word_o = rd_data;
            vram_pkg::REG_INCR:    rd_word_o = incr;
            vram_pkg::REG_STATUS:  rd_word_o[vram_pkg::STATUS_BUSY_BIT] = busy;
            default:               rd_word_o = scratch[scratch_idx];
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            wr_addr  <= '0;
            rd_addr  <= '0;
            incr     <= '0;
            wr_data  <= '0;
            rd_data  <= '0;
            for (int i = 0; i < NUM_SCRATCH; i++) begin
                scratch[i] <= '0;
            end
            wr_pend  <= 1'b0;
            rd_odd   <= 1'b0;
            rd_state <= vram_pkg::RD_IDLE;
            credits  <= CREDIT_W'(QUEUE_DEPTH);          // whole queue free
        end else begin
            credits <= credits - CREDIT_W'(req_valid_o) + CREDIT_W'(credit_return_i);

            if (req_valid_o && wr_pend) begin
                wr_pend <= 1'b0;                          // write got its slot
            end

            case (rd_state)
                vram_pkg::RD_ISSUE: begin
                    if (rd_issue) begin
                        rd_state <= vram_pkg::RD_WAIT;
                    end
                end
                vram_pkg::RD_WAIT: begin
                    if (rsp_valid_i) begin
                        rd_data  <= rsp_data_i;           // prefetch done
                        rd_state <= vram_pkg::RD_IDLE;
                    end
                end
                default: begin
                end
            endcase

            if (write_strobe_i) begin
                case (reg_num_i)
                    vram_pkg::REG_WR_ADDR: wr_addr <= reg_data_i;
                    vram_pkg::REG_WR_DATA: begin
                        wr_data <= reg_data_i;
                        wr_pend <= 1'b1;                  // a second one overwrites, host polls busy
                        wr_addr <= wr_addr + incr;
                    end
                    vram_pkg::REG_RD_ADDR: begin
                        rd_addr  <= reg_data_i;
                        rd_odd   <= 1'b0;                 // next read starts on the even byte
                        rd_state <= vram_pkg::RD_ISSUE;
                    end
                    vram_pkg::REG_RD_DATA, vram_pkg::REG_STATUS: begin
                    end
                    vram_pkg::REG_INCR:    incr <= reg_data_i;
                    default:               scratch[scratch_idx] <= reg_data_i;
                endcase
            end

            if (rd_data_strobe) begin
                rd_odd <= !rd_odd;
                if (rd_odd) begin
                    rd_addr  <= rd_addr + incr;           // word consumed, fetch the next one
                    rd_state <= vram_pkg::RD_ISSUE;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (write_strobe_i && reg_num_i == vram_pkg::REG_WR_DATA) begin
            wr_pend_addr <= wr_addr;                     // address before the step
        end
    end

endmodule

`default_nettype wire

// ==== design/vram_port.sv ====
`default_nettype none
`timescale 1ns/1ps

module vram_port #(
    parameter int VRAM_AW     = 10,
    parameter int QUEUE_DEPTH = 4
) (
    input  logic                clk,
    input  logic                reset_i,
    input  logic                req_valid_i,       // sender holds a credit for it
    input  vram_pkg::vram_req_t req_i,
    output logic                credit_return_o,   // high in the cycle a slot is freed
    output logic                rsp_valid_o,       // one clock after the read left the queue
    output vram_pkg::word_t     rsp_data_o
);

    localparam int PTR_W     = (QUEUE_DEPTH > 1) ? $clog2(QUEUE_DEPTH) : 1;
    localparam int CNT_W     = $clog2(QUEUE_DEPTH + 1);
    localparam int MEM_WORDS = 1 << VRAM_AW;

    vram_pkg::vram_req_t queue [QUEUE_DEPTH];   // request slots
    vram_pkg::word_t     mem   [MEM_WORDS];     // single port word memory
    logic [PTR_W-1:0]    wr_ptr;
    logic [PTR_W-1:0]    rd_ptr;
    logic [CNT_W-1:0]    count;                 // filled slots
    logic                pop;                   // oldest request served this cycle
    vram_pkg::vram_req_t head;
    logic [VRAM_AW-1:0]  head_addr;             // wrapped to the memory size

    function automatic logic [PTR_W-1:0] ptr_next(input logic [PTR_W-1:0] ptr);
        return (ptr == PTR_W'(QUEUE_DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign pop             = (count != '0);
    assign credit_return_o = pop;
    assign head            = queue[rd_ptr];
    assign head_addr       = head.addr[VRAM_AW-1:0];

    always_ff @(posedge clk) begin
        if (reset_i) begin
            wr_ptr      <= '0;
            rd_ptr      <= '0;
            count       <= '0;
            rsp_valid_o <= 1'b0;
        end else begin
            if (req_valid_i) begin
                wr_ptr <= ptr_next(wr_ptr);
            end
            if (pop) begin
                rd_ptr <= ptr_next(rd_ptr);
            end
            count       <= count + CNT_W'(req_valid_i) - CNT_W'(pop);
            rsp_valid_o <= pop && !head.wr;
        end
    end

    always_ff @(posedge clk) begin
        if (req_valid_i) begin
            queue[wr_ptr] <= req_i;
        end
        if (pop) begin
            if (head.wr) begin
                mem[head_addr] <= head.data;
            end else begin
                rsp_data_o <= mem[head_addr];     // read answered next clock
            end
        end
    end

endmodule

`default_nettype wire

// ==== design/vram_top.sv ====
`default_nettype none
`timescale 1ns/1ps

module vram_top #(
    parameter int VRAM_AW     = 10,    // 1024 words by default
    parameter int QUEUE_DEPTH = 4      // request slots and credits
) (
    input  logic               clk,
    input  logic               reset_i,
    input  logic               bus_cs_n_i,
    input  logic               bus_rd_nwr_i,
    input  vram_pkg::reg_num_t bus_reg_num_i,
    input  logic               bus_bytesel_i,
    input  vram_pkg::byte_t    bus_data_i,
    output vram_pkg::byte_t    bus_data_o
);

    logic                write_strobe;
    logic                read_strobe;
    vram_pkg::reg_num_t  reg_num;
    vram_pkg::word_t     reg_wr_word;     // bus to registers
    vram_pkg::word_t     reg_rd_word;     // registers to bus
    logic                req_valid;
    vram_pkg::vram_req_t req;
    logic                credit_return;
    logic                rsp_valid;
    vram_pkg::word_t     rsp_data;

    bus_interface u_bus (
        .clk            (clk),
        .reset_i        (reset_i),
        .bus_cs_n_i     (bus_cs_n_i),
        .bus_rd_nwr_i   (bus_rd_nwr_i),
        .bus_reg_num_i  (bus_reg_num_i),
        .bus_bytesel_i  (bus_bytesel_i),
        .bus_data_i     (bus_data_i),
        .bus_data_o     (bus_data_o),
        .write_strobe_o (write_strobe),
        .read_strobe_o  (read_strobe),
        .reg_num_o      (reg_num),
        .reg_data_o     (reg_wr_word),
        .reg_data_i     (reg_rd_word)
    );

    reg_block #(
        .VRAM_AW     (VRAM_AW),
        .QUEUE_DEPTH (QUEUE_DEPTH)
    ) u_regs (
        .clk             (clk),
        .reset_i         (reset_i),
        .write_strobe_i  (write_strobe),
        .read_strobe_i   (read_strobe),
        .reg_num_i       (reg_num),
        .reg_data_i      (reg_wr_word),
        .rd_word_o       (reg_rd_word),
        .req_valid_o     (req_valid),
        .req_o           (req),
        .credit_return_i (credit_return),
        .rsp_valid_i     (rsp_valid),
        .rsp_data_i      (rsp_data)
    );

    vram_port #(
        .VRAM_AW     (VRAM_AW),
        .QUEUE_DEPTH (QUEUE_DEPTH)
    ) u_vram (
        .clk             (clk),
        .reset_i         (reset_i),
        .req_valid_i     (req_valid),
        .req_i           (req),
        .credit_return_o (credit_return),
        .rsp_valid_o     (rsp_valid),
        .rsp_data_o      (rsp_data)
    );

endmodule

`default_nettype wire

// ==== verif/vram_tb.sv ====
`default_nettype none
`timescale 1ns/1ps

module vram_tb;

    localparam int VRAM_AW     = 10;
    localparam int QUEUE_DEPTH = 4;
    localparam int MEM_WORDS   = 1 << VRAM_AW;
    localparam int BURST       = 12;                 // words per vram burst test

    logic               clk;
    logic               reset_i;
    logic               bus_cs_n;
    logic               bus_rd_nwr;
    vram_pkg::reg_num_t bus_reg_num;
    logic               bus_bytesel;
    vram_pkg::byte_t    bus_wdata;
    vram_pkg::byte_t    bus_rdata;

    logic [15:0]          lfsr_state = 16'd54373;
    longint               cycle_cnt  = 0;            // time base for the busy timeout
    vram_pkg::word_t      model_mem [MEM_WORDS];     // expected vram contents
    vram_pkg::word_t      model_scratch [16];        // indexed by register number
    vram_pkg::vram_addr_t model_wr_addr;
    vram_pkg::vram_addr_t model_rd_addr;
    vram_pkg::word_t      model_incr;

    string                name_q [$];                // pending compares in order
    vram_pkg::word_t      got_q [$];
    vram_pkg::word_t      exp_q [$];

    vram_top #(
        .VRAM_AW     (VRAM_AW),
        .QUEUE_DEPTH (QUEUE_DEPTH)
    ) UUT (
        .clk           (clk),
        .reset_i       (reset_i),
        .bus_cs_n_i    (bus_cs_n),
        .bus_rd_nwr_i  (bus_rd_nwr),
        .bus_reg_num_i (bus_reg_num),
        .bus_bytesel_i (bus_bytesel),
        .bus_data_i    (bus_wdata),
        .bus_data_o    (bus_rdata)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
    end

    // galois form with taps for x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    function automatic logic [15:0] rand_bits(input int n);
        logic [15:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v          = {v[14:0], lfsr_state[0]};   // one step per bit
            lfsr_state = lfsr_next(lfsr_state);
        end
        return v;
    endfunction

    // next RD_DATA word with the read pointer stepped once it is consumed
    function automatic vram_pkg::word_t expect_read();
        vram_pkg::word_t w;
        w             = model_mem[model_rd_addr[VRAM_AW-1:0]];    // memory sees low bits only
        model_rd_addr = model_rd_addr + model_incr;
        return w;
    endfunction

    task automatic check(input string name, input vram_pkg::word_t got,
                         input vram_pkg::word_t exp);
        if (got !== exp) begin
            $display("[ERROR] %s: got 0x%04h, expected 0x%04h", name, got, exp);
            $display("FAIL: see errors above");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic queue_compare(input string name, input vram_pkg::word_t got,
                                 input vram_pkg::word_t exp);
        name_q.push_back(name);
        got_q.push_back(got);
        exp_q.push_back(exp);
    endtask

    // comparator drains whatever the stimulus queued
    always @(posedge clk) begin
        while (got_q.size() != 0) begin
            check(name_q.pop_front(), got_q.pop_front(), exp_q.pop_front());
        end
    end

    task automatic apply_reset();
        @(posedge clk);
        reset_i <= 1'b1;
        repeat (5) @(posedge clk);
        reset_i <= 1'b0;
    endtask

    // one byte access with the address set up before select falls
    task automatic bus_access(input logic rd, input vram_pkg::reg_num_t r,
                              input logic bsel, input vram_pkg::byte_t d,
                              output vram_pkg::byte_t q);
        @(posedge clk);
        bus_rd_nwr  <= rd;
        bus_reg_num <= r;
        bus_bytesel <= bsel;
        bus_wdata   <= d;
        repeat (2) @(posedge clk);
        bus_cs_n <= 1'b0;
        repeat (8) @(posedge clk);
        @(negedge clk);
        q = bus_rdata;                               // held since the select edge
        @(posedge clk);
        bus_cs_n <= 1'b1;
        repeat (8) @(posedge clk);                   // idle gap with the address kept
    endtask

    task automatic bus_write_word(input vram_pkg::reg_num_t r, input vram_pkg::word_t w);
        vram_pkg::byte_t q;
        bus_access(1'b0, r, 1'b0, w[15:8], q);       // even byte is the high byte
        bus_access(1'b0, r, 1'b1, w[7:0], q);
    endtask

    task automatic bus_read_word(input vram_pkg::reg_num_t r, output vram_pkg::word_t w);
        vram_pkg::byte_t hi;
        vram_pkg::byte_t lo;
        bus_access(1'b1, r, 1'b0, 8'h00, hi);
        bus_access(1'b1, r, 1'b1, 8'h00, lo);
        w = {hi, lo};
    endtask

    task automatic wait_not_busy();
        vram_pkg::word_t status;
        longint          start;
        start = cycle_cnt;
        bus_read_word(vram_pkg::REG_STATUS, status);
        while (status[vram_pkg::STATUS_BUSY_BIT] !== 1'b0) begin
            if (cycle_cnt - start > 200) begin
                $display("wait_not_busy: STATUS busy bit still set after 200 clocks");
                $display("FAIL: see errors above");
                $fatal(1, "busy timeout");
            end
            bus_read_word(vram_pkg::REG_STATUS, status);
        end
    endtask

    // write a burst through WR_DATA and stream it back through RD_DATA
    task automatic run_burst(input vram_pkg::vram_addr_t base, input vram_pkg::word_t step);
        vram_pkg::word_t w;
        vram_pkg::word_t rd;
        w = '0;
        bus_write_word(vram_pkg::REG_INCR, step);
        model_incr = step;
        bus_write_word(vram_pkg::REG_WR_ADDR, base);
        model_wr_addr = base;
        for (int i = 0; i < BURST; i++) begin
            w = rand_bits(16);
            bus_write_word(vram_pkg::REG_WR_DATA, w);
            model_mem[model_wr_addr[VRAM_AW-1:0]] = w;
            model_wr_addr = model_wr_addr + model_incr;
            wait_not_busy();
        end
        bus_read_word(vram_pkg::REG_WR_DATA, rd);
        queue_compare("WR_DATA", rd, w);             // last word written
        bus_write_word(vram_pkg::REG_RD_ADDR, base);
        model_rd_addr = base;
        for (int i = 0; i < BURST; i++) begin
            wait_not_busy();                         // prefetch landed
            bus_read_word(vram_pkg::REG_RD_DATA, rd);
            queue_compare($sformatf("RD_DATA[%0d]", i), rd, expect_read());
        end
    endtask

    initial begin
        vram_pkg::word_t      w;
        vram_pkg::word_t      rd;
        vram_pkg::byte_t      q;
        vram_pkg::vram_addr_t base;
        vram_pkg::word_t      step;
        reset_i       = 1'b1;
        bus_cs_n      = 1'b1;
        bus_rd_nwr    = 1'b0;
        bus_reg_num   = '0;
        bus_bytesel   = 1'b0;
        bus_wdata     = '0;
        model_wr_addr = '0;
        model_rd_addr = '0;
        model_incr    = '0;
        apply_reset();

        // scratch registers over both byte lanes
        for (int r = 6; r < 16; r++) begin
            w = rand_bits(16);
            bus_write_word(vram_pkg::reg_num_t'(r), w);
            model_scratch[r] = w;
        end
        for (int r = 6; r < 16; r++) begin
            bus_read_word(vram_pkg::reg_num_t'(r), rd);
            queue_compare($sformatf("scratch[%0d]", r), rd, model_scratch[r]);
        end

        // even byte to reg 6 and a lone odd byte to reg 7
        w = rand_bits(16);
        bus_access(1'b0, 4'd6, 1'b0, w[15:8], q);    // never completed so reg 6 keeps its word
        bus_access(1'b0, 4'd7, 1'b1, w[7:0], q);
        model_scratch[7] = {8'h00, w[7:0]};
        bus_read_word(4'd7, rd);
        queue_compare("scratch[7] lone odd", rd, model_scratch[7]);
        bus_read_word(4'd6, rd);
        queue_compare("scratch[6] unpaired even", rd, model_scratch[6]);

        run_burst(rand_bits(16), 16'd1);             // unit step

        // step of 2..7 from just below a 1K boundary so the burst wraps
        base = (rand_bits(6) << 10) | 16'h03F0 | rand_bits(3);
        step = 16'd2 + (rand_bits(3) % 16'd6);
        run_burst(base, step);

        wait_not_busy();
        bus_read_word(vram_pkg::REG_STATUS, rd);
        queue_compare("STATUS", rd, 16'h0000);
        bus_read_word(vram_pkg::REG_WR_ADDR, rd);
        queue_compare("WR_ADDR", rd, model_wr_addr);
        bus_read_word(vram_pkg::REG_RD_ADDR, rd);
        queue_compare("RD_ADDR", rd, model_rd_addr);

        // reset in the middle of the run
        apply_reset();
        model_incr = '0;
        for (int r = 6; r < 16; r++) begin
            model_scratch[r] = '0;
        end
        bus_read_word(4'd9, rd);
        queue_compare("scratch[9] after reset", rd, model_scratch[9]);
        bus_read_word(vram_pkg::REG_INCR, rd);
        queue_compare("INCR after reset", rd, model_incr);

        for (int i = 0; i < 10 && got_q.size() != 0; i++) begin
            @(posedge clk);                          // let the comparator catch up
        end
        if (got_q.size() != 0) begin
            $display("comparator did not drain its queue within 10 clocks");
            $display("FAIL: see errors above");
            $fatal(1, "compare queue stuck");
        end else begin
            $display("PASS: all tests");
            $finish;
        end
    end

endmodule

`default_nettype wire

// ==== verilog.f ====
design/vram_pkg.sv
design/bus_interface.sv
design/reg_block.sv
design/vram_port.sv
design/vram_top.sv
verif/vram_tb.sv

// ==== Makefile ====
# Verilator build and run for the vram register window

VERILATOR ?= verilator
TOP       ?= vram_tb
FILELIST  ?= verilog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -j 0
LINTFLAGS ?= --lint-only -Wall --timing
PASS_MSG  := PASS: all tests

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -qx "$(PASS_MSG)" $(LOG)

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
